/* common/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_BYTES     = 16;
    localparam int CACHE_LINES    = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 4;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;  // Word 0 sits in the low bits
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_COMPARE,
        IC_REFILL,
        IC_FENCE
    } icache_state_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_READ,   // One-cycle word read request
        RF_WAIT,
        RF_DONE
    } refill_state_t;

endpackage

/* common/fetch_pkg.sv */
package fetch_pkg;

    // First instruction fetched after reset
    localparam icache_pkg::addr_t RESET_PC = 32'h0000_1000;

    localparam icache_pkg::addr_t INSTR_BYTES = 32'd4;

    typedef enum logic [1:0] {
        FT_ISSUE,  // Free to send a fetch or a fence to the cache
        FT_WAIT,
        FT_HOLD    // Instruction on the outputs until stall drops
    } fetch_state_t;

endpackage

/* common/fetch_if.sv */
interface fetch_if
    import icache_pkg::*;
();
    logic  req;    // One-cycle fetch request
    addr_t addr;   // Held from req until ready
    logic  fence;  // One-cycle invalidate request
    word_t data;
    logic  ready;  // One-cycle answer to req or fence
    logic  hit;    // Set together with ready when the line was present

    modport fetch (
        output req,
        output addr,
        output fence,
        input  data,
        input  ready,
        input  hit
    );

    modport cache (
        input  req,
        input  addr,
        input  fence,
        output data,
        output ready,
        output hit
    );
endinterface

/* common/refill_if.sv */
interface refill_if
    import icache_pkg::*;
();
    logic  req;        // Level, high until ready pulses
    addr_t line_addr;  // Line aligned
    line_t line;       // Valid in the ready cycle
    logic  ready;

    modport cache (
        output req,
        output line_addr,
        input  line,
        input  ready
    );

    modport engine (
        input  req,
        input  line_addr,
        output line,
        output ready
    );
endinterface

/* icache/refill_engine.sv */
module refill_engine
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    refill_if.engine  rif,
    output logic      mem_rd_req,
    output addr_t     mem_rd_addr,
    input  word_t     mem_rd_data,
    input  logic      mem_rd_valid
);

    refill_state_t state;
    logic [$clog2(WORDS_PER_LINE)-1:0] word_cnt;
    logic  last_word;
    line_t line_q;

    assign last_word = &word_cnt;

    assign mem_rd_req  = (state == RF_READ);
    assign mem_rd_addr = {rif.line_addr[ADDR_W-1:OFFSET_W], word_cnt,
                          {(OFFSET_W - $bits(word_cnt)){1'b0}}};

    assign rif.ready = (state == RF_DONE);
    assign rif.line  = line_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RF_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    word_cnt <= '0;
                    if (rif.req) begin
                        state <= RF_READ;
                    end
                end
                RF_READ: begin
                    state <= RF_WAIT;
                end
                RF_WAIT: begin
                    if (mem_rd_valid) begin
                        if (last_word) begin
                            state <= RF_DONE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= RF_READ;  // Next read one cycle after the answer
                        end
                    end
                end
                RF_DONE: begin
                    state <= RF_IDLE;  // The cache lowers req in the same edge
                end
                default: begin
                    state <= RF_IDLE;
                end
            endcase
        end
    end

    // Each answer lands in the slot of the word it was read for
    always_ff @(posedge clk) begin
        if (state == RF_WAIT && mem_rd_valid) begin
            line_q[word_cnt*WORD_W +: WORD_W] <= mem_rd_data;
        end
    end

endmodule

/* icache/icache.sv */
module icache
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    fetch_if.cache  fif,
    refill_if.cache rif
);

    tag_t    tag;
    index_t  index;
    offset_t offset;
    logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;

    tag_t  tag_array  [CACHE_LINES];
    line_t data_array [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_array;

    icache_state_t state;
    icache_state_t state_nxt;
    logic          lookup_hit;
    logic          refill_done;

    assign tag      = fif.addr[ADDR_W-1 -: TAG_W];
    assign index    = fif.addr[OFFSET_W +: INDEX_W];
    assign offset   = fif.addr[OFFSET_W-1:0];
    assign word_sel = offset[OFFSET_W-1 -: $clog2(WORDS_PER_LINE)];  // Byte bits dropped

    assign rif.line_addr = {tag, index, {OFFSET_W{1'b0}}};

    // Lookup result is only meaningful in COMPARE, while addr is held stable
    assign lookup_hit  = (state == IC_COMPARE) && valid_array[index]
                         && (tag_array[index] == tag);
    assign refill_done = (state == IC_REFILL) && rif.ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IC_IDLE: begin
                if (fif.fence) begin
                    state_nxt = IC_FENCE;
                end else if (fif.req) begin
                    state_nxt = IC_COMPARE;
                end
            end
            IC_COMPARE: begin
                state_nxt = lookup_hit ? IC_IDLE : IC_REFILL;
            end
            IC_REFILL: begin
                if (rif.ready) begin
                    state_nxt = IC_IDLE;
                end
            end
            IC_FENCE: begin
                state_nxt = IC_IDLE;
            end
            default: begin
                state_nxt = IC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IC_IDLE;
            fif.ready   <= 1'b0;
            fif.hit     <= 1'b0;
            rif.req     <= 1'b0;
            valid_array <= '0;
        end else begin
            state   <= state_nxt;
            fif.hit <= lookup_hit;
            case (state)
                IC_COMPARE: begin
                    fif.ready <= lookup_hit;
                    rif.req   <= !lookup_hit;  // Refill starts the cycle after the miss
                end
                IC_REFILL: begin
                    fif.ready <= rif.ready;
                    rif.req   <= !rif.ready;  // Dropped right after the line arrives
                end
                IC_FENCE: begin
                    fif.ready <= 1'b1;
                    rif.req   <= 1'b0;
                end
                default: begin
                    fif.ready <= 1'b0;
                    rif.req   <= 1'b0;
                end
            endcase

            if (state == IC_FENCE) begin
                valid_array <= '0;
            end else if (refill_done) begin
                valid_array[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_array[index]  <= tag;
            data_array[index] <= rif.line;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            fif.data <= data_array[index][word_sel*WORD_W +: WORD_W];
        end else if (refill_done) begin
            fif.data <= rif.line[word_sel*WORD_W +: WORD_W];  // Forward from the new line
        end else if (state == IC_FENCE) begin
            fif.data <= '0;
        end
    end

endmodule

/* verilog/fetch_unit.sv */
module fetch_unit
    import icache_pkg::*;
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    fetch_if.fetch fif,
    input  logic   redirect,
    input  addr_t  redirect_pc,
    input  logic   fence_i,
    input  logic   stall,
    output logic   instr_valid,
    output word_t  instr,
    output addr_t  instr_pc
);

    fetch_state_t state;
    addr_t        pc;
    logic         fence_pend;
    logic         redir_pend;
    addr_t        redir_target;
    logic         wait_fence;  // Outstanding request is a fence
    logic         issue_ok;
    logic         redir_any;
    addr_t        redir_pc_any;

    assign issue_ok  = (state == FT_ISSUE) && !redirect;
    assign fif.req   = issue_ok && !fence_pend;
    assign fif.fence = issue_ok && fence_pend;  // A pending fence goes out before any fetch
    assign fif.addr  = pc;

    // A redirect seen in the ready cycle itself wins over an older one
    assign redir_any    = redirect || redir_pend;
    assign redir_pc_any = redirect ? redirect_pc : redir_target;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= FT_ISSUE;
            pc          <= RESET_PC;
            fence_pend  <= 1'b0;
            redir_pend  <= 1'b0;
            wait_fence  <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (fence_i) begin
                fence_pend <= 1'b1;
            end else if (fif.fence) begin
                fence_pend <= 1'b0;
            end

            case (state)
                FT_ISSUE: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                    end else begin
                        wait_fence <= fence_pend;
                        state      <= FT_WAIT;
                    end
                end
                FT_WAIT: begin
                    if (fif.ready) begin
                        redir_pend <= 1'b0;
                        if (redir_any) begin
                            pc    <= redir_pc_any;  // Result of the old stream is dropped
                            state <= FT_ISSUE;
                        end else if (wait_fence) begin
                            state <= FT_ISSUE;
                        end else begin
                            instr_valid <= 1'b1;
                            state       <= FT_HOLD;
                        end
                    end else if (redirect) begin
                        redir_pend <= 1'b1;
                    end
                end
                FT_HOLD: begin
                    if (redirect) begin
                        instr_valid <= 1'b0;
                        pc          <= redirect_pc;
                        state       <= FT_ISSUE;
                    end else if (!stall) begin
                        instr_valid <= 1'b0;
                        pc          <= pc + INSTR_BYTES;
                        state       <= FT_ISSUE;
                    end
                end
                default: begin
                    state <= FT_ISSUE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FT_WAIT && redirect) begin
            redir_target <= redirect_pc;
        end
        if (state == FT_WAIT && fif.ready) begin
            instr    <= fif.data;
            instr_pc <= pc;
        end
    end

endmodule

/* verilog/ifetch_top.sv */
module ifetch_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  fence_i,
    input  logic  stall,
    output logic  instr_valid,
    output word_t instr,
    output addr_t instr_pc,
    output logic  mem_rd_req,
    output addr_t mem_rd_addr,
    input  word_t mem_rd_data,
    input  logic  mem_rd_valid
);

    fetch_if  fif ();
    refill_if rif ();

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst         (rst),
        .fif         (fif.fetch),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fence_i     (fence_i),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    icache icache_i (
        .clk (clk),
        .rst (rst),
        .fif (fif.cache),
        .rif (rif.cache)
    );

    // Only block that talks to the external instruction memory
    refill_engine refill_engine_i (
        .clk          (clk),
        .rst          (rst),
        .rif          (rif.engine),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_valid (mem_rd_valid)
    );

endmodule

/* verification/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

/* verification/tb_ifetch_top.sv */
module tb_ifetch_top
    import icache_pkg::*;
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD         = 10;
    localparam int TOTAL_FETCHES      = 200;
    localparam int WORST_FETCH_CYCLES = 64;  // Four slow word reads plus stall stretches
    localparam int MAX_LATENCY        = 4;

    logic  clk;
    logic  rst;
    logic  redirect;
    addr_t redirect_pc;
    logic  fence_i;
    logic  stall;
    logic  instr_valid;
    word_t instr;
    addr_t instr_pc;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    word_t mem_rd_data;
    logic  mem_rd_valid;

    logic [31:0] rng_state = 32'd33;
    int errors = 0;
    int checks = 0;
    int delivered = 0;
    int mem_reads = 0;
    int exp_reads = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    addr_t exp_pc = RESET_PC;
    logic [23:0] ref_tags [16];
    logic [15:0] ref_valid = '0;
    logic  prev_iv = 1'b0;
    logic  prev_stall = 1'b0;
    logic  prev_redirect = 1'b0;
    word_t prev_instr;
    addr_t prev_pc;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    ifetch_top ifetch_top_i (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fence_i      (fence_i),
        .stall        (stall),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_valid (mem_rd_valid)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t mem_word(addr_t addr);
        logic [31:0] x;
        x = addr ^ 32'hA5A5_0F0F;
        return {x[15:0], x[31:16]};  // Halves swapped
    endfunction

    // Reference lookup in a 16 line cache of 16 byte lines, returns 1 on a miss
    function automatic logic ref_lookup(addr_t pc);
        if (ref_valid[pc[7:4]] && ref_tags[pc[7:4]] == pc[31:8]) begin
            return 1'b0;
        end
        ref_valid[pc[7:4]] = 1'b1;
        ref_tags[pc[7:4]]  = pc[31:8];
        return 1'b1;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_iv && prev_stall && !prev_redirect) begin
                check_value("instr_valid under stall", 32'(instr_valid), 32'd1);
                check_value("instr under stall", instr, prev_instr);
                check_value("instr_pc under stall", instr_pc, prev_pc);
            end
            if (instr_valid && !prev_iv) begin
                check_value("instr_pc", instr_pc, exp_pc);
                check_value("instr", instr, mem_word(exp_pc));
                if (ref_lookup(exp_pc)) begin
                    exp_reads += 4;  // One line is four word reads
                end
                exp_pc = exp_pc + 32'd4;
                delivered++;
            end
            if (fence_i) begin
                ref_valid = '0;
            end
            if (redirect) begin
                exp_pc = redirect_pc;
            end
            prev_iv       = instr_valid;
            prev_stall    = stall;
            prev_redirect = redirect;
            prev_instr    = instr;
            prev_pc       = instr_pc;
        end
    end

    initial begin
        addr_t      req_addr;
        int         latency;
        logic [1:0] slot;
        mem_rd_data  = '0;
        mem_rd_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_rd_req) begin
                req_addr = mem_rd_addr;
                slot     = mem_reads[1:0];  // Words of a line are read in order
                check_value("mem_rd_addr", req_addr, {exp_pc[31:4], slot, 2'b00});
                latency  = 1 + int'(xorshift32() % MAX_LATENCY);
                mem_reads++;
                repeat (latency) @(posedge clk);
                mem_rd_data  <= mem_word(req_addr);
                mem_rd_valid <= 1'b1;
                @(posedge clk);
                mem_rd_valid <= 1'b0;
            end
        end
    end

    task automatic wait_deliveries(int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(posedge clk);
    endtask

    // Leaves the DUT holding the next instruction with no fetch in flight
    task automatic hold_next();
        int target;
        target = delivered + 1;
        stall <= 1'b1;
        while (delivered < target) @(posedge clk);
    endtask

    task automatic stream(int n);
        stall <= 1'b0;
        @(posedge clk);
        wait_deliveries(n - 1);
        hold_next();
    endtask

    task automatic stream_stalled(int n);
        int          target;
        int          left;
        logic [31:0] r;
        logic        level;
        target = delivered + n - 1;
        left   = 0;
        level  = 1'b0;
        while (delivered < target) begin
            if (left == 0) begin
                r     = xorshift32();
                level = r[0];
                left  = 1 + int'(r[10:8]);
            end
            stall <= level;
            left--;
            @(posedge clk);
        end
        stall <= 1'b0;
        @(posedge clk);
        hold_next();
    endtask

    task automatic jump(addr_t pc);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic pulse_fence();
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
    endtask

    task automatic finish_test(string name, int errors_before);
        check_value({name, " memory reads"}, mem_reads, exp_reads);
        if (errors == errors_before) begin
            tests_passed++;
            $display("PASS %s: %0d delivered, %0d reads", name, delivered, mem_reads);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int          err0;
        int          reads0;
        logic [31:0] r;
        redirect    = 1'b0;
        redirect_pc = '0;
        fence_i     = 1'b0;
        stall       = 1'b0;
        @(negedge rst);
        @(posedge clk);

        err0 = errors;
        wait_deliveries(7);
        hold_next();
        finish_test("reset stream", err0);

        err0   = errors;
        reads0 = mem_reads;
        jump(32'h0000_2040);
        stream(16);
        check_value("first pass reads", mem_reads - reads0, 16);
        reads0 = mem_reads;
        jump(32'h0000_2040);
        stream(16);
        check_value("second pass reads", mem_reads - reads0, 0);
        finish_test("straight run twice", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            r = xorshift32();
            jump({12'h000, r[19:2], 2'b00});
            stream(2 + int'(r[21:20]));
        end
        jump(32'h0000_2040);
        stream(4);
        reads0 = mem_reads;
        jump(32'h0000_3040);  // Same index as 0x2040, other tag
        stream(4);
        check_value("conflict miss reads", mem_reads - reads0, 4);
        finish_test("redirects", err0);

        err0 = errors;
        jump(32'h0000_2040);
        stream(8);
        reads0 = mem_reads;
        jump(32'h0000_2040);
        stream(8);
        check_value("reads before fence", mem_reads - reads0, 0);
        pulse_fence();
        reads0 = mem_reads;
        jump(32'h0000_2040);
        stream(8);
        check_value("reads after fence", mem_reads - reads0, 8);
        finish_test("fence.i", err0);

        err0 = errors;
        jump(32'h0000_2040);
        stream_stalled(12);
        jump(32'h0000_5000);
        stream_stalled(24);
        finish_test("stall hold", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            r = xorshift32();
            jump({16'h0000, r[15:2], 2'b00});
            stream_stalled(6 + int'(r[26:24]));
        end
        finish_test("random latency", err0);

        $display("Tests: %0d passed, %0d failed; %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_FETCHES * WORST_FETCH_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time, %0d instructions delivered",
                 delivered);
        $display("Testbench failed");
        $finish;
    end
endmodule

/* project.f */
common/icache_pkg.sv
common/fetch_pkg.sv
common/fetch_if.sv
common/refill_if.sv
icache/refill_engine.sv
icache/icache.sv
verilog/fetch_unit.sv
verilog/ifetch_top.sv
verification/clk_gen.sv
verification/tb_ifetch_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ifetch_top -f project.f \
    -Mdir obj_dir -o sim_ifetch > build.log 2>&1 \
    && ./obj_dir/sim_ifetch > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "FAIL: build or simulation error"; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
